//--- verification/hex_ctrl_tests.txt
# name  op  addr  be  data  expected, all numbers hex
# op: W write, R check readback, S scan window, L lfsr writes (data is the count)
rst_val         R 00000000 0 00000000 00000000
rst_ctrl        R 00000008 0 00000000 00000000
rst_scan        S 00000000 0 00000000 00000000
val_all         W 00000000 f 00004321 00000000
val_all_rd      R 00000000 0 00000000 00004321
val_be0         W 00000000 1 0000ffff 00000000
val_be0_rd      R 00000000 0 00000000 0000432f
val_be2         W 00000000 4 0000aaaa 00000000
val_be2_rd      R 00000000 0 00000000 00004a2f
val_be13        W 00000000 a 00005678 00000000
val_be13_rd     R 00000000 0 00000000 00005a7f
val_be_none     W 00000000 0 0000ffff 00000000
val_be_none_rd  R 00000000 0 00000000 00005a7f
val_hi          W 00000000 f ffff0c0d 00000000
val_hi_rd       R 00000000 0 00000000 00000c0d
ctrl_en         W 00000008 1 0000ff0f 00000000
ctrl_en_rd      R 00000008 0 00000000 0000000f
ctrl_blk        W 00000008 2 0000ff05 00000000
ctrl_blk_rd     R 00000008 0 00000000 0000ff0f
val_kept_rd     R 00000000 0 00000000 00000c0d
scan_all        S 00000000 0 00000000 00000000
en_02           W 00000008 1 00000005 00000000
en_02_rd        R 00000008 0 00000000 0000ff05
scan_en_02      S 00000000 0 00000000 00000000
blink2          W 00000008 2 00000200 00000000
blink2_rd       R 00000008 0 00000000 00000205
scan_blink2     S 00000000 0 00000000 00000000
blink0          W 00000008 3 0000000f 00000000
blink0_rd       R 00000008 0 00000000 0000000f
scan_blink0     S 00000000 0 00000000 00000000
blink4          W 00000008 2 00000400 00000000
blink4_rd       R 00000008 0 00000000 0000040f
scan_blink4     S 00000000 0 00000000 00000000
lfsr_val        L 00000000 0 00000020 00000000
scan_lfsr       S 00000000 0 00000000 00000000

//--- vlog.f
rtl/hex_pkg.sv
rtl/hex_regs.sv
rtl/hex_blink.sv
rtl/hex_scan.sv
rtl/hex_ctrl.sv
verification/hex_ctrl_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = hex_ctrl_tb
FLIST = vlog.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- verification/hex_ctrl_tb.sv
`timescale 1ns/1ps

module hex_ctrl_tb;

  import hex_pkg::*;

  localparam int unsigned BLINK_HALF = 64;
  localparam int unsigned SCAN       = 4;
  localparam int          WINDOW     = 4 * BLINK_HALF; // two full blink periods
  localparam int          DARK_GAP   = NUM_DIGITS * SCAN;
  localparam time         DRIVE_DLY  = 1;

  logic        clk_i;
  logic        rst_i;
  logic [31:0] wdata_i;
  logic [31:0] addr_i;
  logic [3:0]  be_i;
  logic        we_i;
  seg_t        seg_o;
  an_t         an_o;
  logic [31:0] out_o;

  logic [15:0] model_value;
  an_t         model_en;
  logic [7:0]  model_blink;
  logic [15:0] lfsr_state;
  int          cycle_cnt;
  int          cycle_limit;

  hex_ctrl #(
    .BLINK_HALF_PERIOD (BLINK_HALF),
    .SCAN_PERIOD       (SCAN)
  ) dut_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wdata_i (wdata_i),
    .addr_i  (addr_i),
    .be_i    (be_i),
    .we_i    (we_i),
    .seg_o   (seg_o),
    .an_o    (an_o),
    .out_o   (out_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      report_error($sformatf("timeout after %0d cycles, tests did not finish", cycle_cnt));
    end
  end

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_seg(input string name, input seg_t exp, input seg_t act);
    if (act !== exp) begin
      $display("[FAIL] %s seg expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_an(input string name, input an_t exp, input an_t act);
    if (act !== exp) begin
      $display("[FAIL] %s anode expected %b actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  // panel patterns as gfedcba, a lit segment is 0
  function automatic seg_t seg_pattern(input hex_digit_t d);
    case (d)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic model_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
    if (hex_reg_e'(addr[3]) == REG_VALUE) begin
      for (int n = 0; n < NUM_DIGITS; n++) begin
        if (be[n]) begin
          model_value[n*4 +: 4] = data[n*4 +: 4];
        end
      end
    end else begin
      if (be[0]) begin
        model_en = data[3:0];
      end
      if (be[1]) begin
        model_blink = data[15:8];
      end
    end
  endtask

  function automatic logic [31:0] model_readback(input logic [31:0] addr);
    if (hex_reg_e'(addr[3]) == REG_VALUE) begin
      return {16'h0000, model_value};
    end
    return {16'h0000, model_blink, 4'h0, model_en};
  endfunction

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data);
    addr_i  = addr;
    be_i    = be;
    wdata_i = data;
    we_i    = 1'b1;
    @(posedge clk_i);
    #DRIVE_DLY;
    we_i = 1'b0;
    model_write(addr, be, data);
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] exp);
    addr_i = addr;
    we_i   = 1'b0;
    #DRIVE_DLY; // out_o is combinational
    check_word(name, exp, out_o);
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic lfsr_writes(input string name, input logic [31:0] addr, input int count);
    logic [31:0] rnd_be;
    logic [31:0] rnd_data;
    for (int i = 0; i < count; i++) begin
      take_bits(4, rnd_be);
      take_bits(16, rnd_data);
      bus_write(addr, rnd_be[3:0], rnd_data);
      read_check($sformatf("%s_%0d", name, i), addr, model_readback(addr));
    end
  endtask

  task automatic scan_window(input string name);
    int                    gap [NUM_DIGITS];
    logic [NUM_DIGITS-1:0] seen_lit;
    logic [NUM_DIGITS-1:0] seen_dark;
    int                    low;
    int                    blink_dig;
    seen_lit  = '0;
    seen_dark = '0;
    blink_dig = (model_blink < 8'(NUM_DIGITS)) ? int'(model_blink) : -1;
    for (int n = 0; n < NUM_DIGITS; n++) begin
      gap[n] = 0;
    end
    repeat (2) @(posedge clk_i); // regs to panel latency
    #DRIVE_DLY;
    for (int c = 0; c < WINDOW; c++) begin
      low = -1;
      for (int n = NUM_DIGITS - 1; n >= 0; n--) begin
        if (!an_o[n]) begin
          low = n;
        end
      end
      if (low < 0) begin
        check_seg(name, '1, seg_o); // blank slot
      end else if (model_en[low]) begin
        check_an(name, ~(an_t'(1) << low), an_o);
        check_seg(name, seg_pattern(model_value[low*4 +: 4]), seg_o);
      end else begin
        check_an(name, '1, an_o); // disabled digit must stay dark
      end
      for (int n = 0; n < NUM_DIGITS; n++) begin
        if (low == n) begin
          gap[n]      = 0;
          seen_lit[n] = 1'b1;
        end else begin
          gap[n] = gap[n] + 1;
          if (gap[n] > DARK_GAP) begin
            seen_dark[n] = 1'b1;
            if (model_en[n] && n != blink_dig) begin
              report_error($sformatf("%s: digit %0d went dark without blinking", name, n));
            end
          end
        end
      end
      @(posedge clk_i);
      #DRIVE_DLY;
    end
    for (int n = 0; n < NUM_DIGITS; n++) begin
      if (model_en[n] && !seen_lit[n]) begin
        report_error($sformatf("%s: digit %0d was never lit", name, n));
      end
      if (model_en[n] && n == blink_dig && !seen_dark[n]) begin
        report_error($sformatf("%s: digit %0d never blinked off", name, n));
      end
    end
  endtask

  // one record per line, a leading # marks a comment line
  task automatic count_tests(output int n_tests);
    int    fd;
    string tok;
    string rest;
    n_tests = 0;
    fd = $fopen("verification/hex_ctrl_tests.txt", "r");
    if (fd == 0) begin
      report_error("cannot open verification/hex_ctrl_tests.txt");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) != "#") begin
        n_tests = n_tests + 1;
      end
      void'($fgets(rest, fd));
    end
    $fclose(fd);
  endtask

  initial begin
    int          fd;
    int          n_tests;
    int          n_fields;
    string       name;
    string       op;
    string       rest;
    logic [31:0] t_addr;
    logic [31:0] t_be;
    logic [31:0] t_data;
    logic [31:0] t_exp;
    rst_i       = 1'b1;
    we_i        = 1'b0;
    wdata_i     = '0;
    addr_i      = '0;
    be_i        = '0;
    cycle_cnt   = 0;
    cycle_limit = 1000;
    lfsr_state  = 16'd13328;
    model_value = '0;
    model_en    = '0;
    model_blink = '0;
    count_tests(n_tests);
    cycle_limit = n_tests * 2 * (2 * BLINK_HALF) * 2;
    repeat (10) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;
    fd = $fopen("verification/hex_ctrl_tests.txt", "r");
    if (fd == 0) begin
      report_error("cannot open verification/hex_ctrl_tests.txt");
    end
    while ($fscanf(fd, "%s", name) == 1) begin
      if (name.substr(0, 0) == "#") begin
        void'($fgets(rest, fd));
      end else begin
        n_fields = $fscanf(fd, "%s %h %h %h %h", op, t_addr, t_be, t_data, t_exp);
        if (n_fields != 5) begin
          report_error($sformatf("test %s has a malformed line", name));
        end
        case (op)
          "W": bus_write(t_addr, t_be[3:0], t_data);
          "R": read_check(name, t_addr, t_exp);
          "S": scan_window(name);
          "L": lfsr_writes(name, t_addr, int'(t_data));
          default: report_error($sformatf("test %s has unknown operation %s", name, op));
        endcase
      end
    end
    $fclose(fd);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- rtl/hex_ctrl.sv
`timescale 1ns/1ps

module hex_ctrl #(
  parameter int unsigned BLINK_HALF_PERIOD = 100000000, // 1 s at 100 MHz
  parameter int unsigned SCAN_PERIOD       = 100000
) (
  input  logic          clk_i,
  input  logic          rst_i,

  input  logic [31:0]   wdata_i,
  input  logic [31:0]   addr_i,
  input  logic [3:0]    be_i,
  input  logic          we_i,

  output hex_pkg::seg_t seg_o,
  output hex_pkg::an_t  an_o,
  output logic [31:0]   out_o
);

  import hex_pkg::*;

  logic [15:0] reg_digits;
  an_t         reg_digit_en;
  logic [7:0]  reg_blink_sel;
  logic [15:0] vis_digits;
  logic [3:0]  vis_mask;

  hex_regs u_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wdata_i     (wdata_i),
    .addr_i      (addr_i),
    .be_i        (be_i),
    .we_i        (we_i),
    .digits_o    (reg_digits),
    .digit_en_o  (reg_digit_en),
    .blink_sel_o (reg_blink_sel),
    .out_o       (out_o)
  );

  hex_blink #(
    .BLINK_HALF_PERIOD (BLINK_HALF_PERIOD)
  ) u_blink (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .digits_i    (reg_digits),
    .digit_en_i  (reg_digit_en),
    .blink_sel_i (reg_blink_sel),
    .digits_o    (vis_digits),
    .visible_o   (vis_mask)
  );

  hex_scan #(
    .SCAN_PERIOD (SCAN_PERIOD)
  ) u_scan (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .digits_i  (vis_digits),
    .visible_i (vis_mask),
    .seg_o     (seg_o),
    .an_o      (an_o)
  );

endmodule

//--- rtl/hex_scan.sv
`timescale 1ns/1ps

module hex_scan #(
  parameter int unsigned SCAN_PERIOD = 100000
) (
  input  logic          clk_i,
  input  logic          rst_i,

  input  logic [15:0]   digits_i,
  input  logic [3:0]    visible_i,

  output hex_pkg::seg_t seg_o,
  output hex_pkg::an_t  an_o
);

  import hex_pkg::*;

  localparam int SLOT_W = (SCAN_PERIOD > 1) ? $clog2(SCAN_PERIOD) : 1;
  localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(SCAN_PERIOD - 1);
  localparam int PTR_W = $clog2(NUM_DIGITS);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(NUM_DIGITS - 1);

  // hex digit to segment pattern, gfedcba, active low
  localparam seg_t SEG_TABLE [16] = '{
    7'h40, // 0
    7'h79, // 1
    7'h24, // 2
    7'h30, // 3
    7'h19, // 4
    7'h12, // 5
    7'h02, // 6
    7'h78, // 7
    7'h00, // 8
    7'h10, // 9
    7'h08, // A
    7'h03, // b
    7'h46, // C
    7'h21, // d
    7'h06, // E
    7'h0E  // F
  };

  logic [SLOT_W-1:0] slot_cnt;
  logic              slot_done;
  logic [PTR_W-1:0]  digit_ptr;
  hex_digit_t        cur_digit;
  logic              cur_visible;
  seg_t              seg_d;
  an_t               an_d;

  assign slot_done = (slot_cnt == SLOT_LAST);

  // time each digit stays lit
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      slot_cnt <= '0;
    end else if (slot_done) begin
      slot_cnt <= '0;
    end else begin
      slot_cnt <= slot_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      digit_ptr <= '0;
    end else if (slot_done) begin
      if (digit_ptr == PTR_LAST) begin
        digit_ptr <= '0;
      end else begin
        digit_ptr <= digit_ptr + 1'b1;
      end
    end
  end

  assign cur_digit   = digits_i[digit_ptr*4 +: 4];
  assign cur_visible = visible_i[digit_ptr];

  always_comb begin
    if (cur_visible) begin
      an_d  = ~(an_t'(1) << digit_ptr); // one-cold
      seg_d = SEG_TABLE[cur_digit];
    end else begin
      an_d  = '1; // blank slot
      seg_d = '1;
    end
  end

  // anode and segments leave together
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      an_o  <= '1;
      seg_o <= '1;
    end else begin
      an_o  <= an_d;
      seg_o <= seg_d;
    end
  end

endmodule

//--- rtl/hex_blink.sv
`timescale 1ns/1ps

module hex_blink #(
  parameter int unsigned BLINK_HALF_PERIOD = 100000000
) (
  input  logic        clk_i,
  input  logic        rst_i,

  input  logic [15:0] digits_i,
  input  logic [3:0]  digit_en_i,
  input  logic [7:0]  blink_sel_i,

  output logic [15:0] digits_o,
  output logic [3:0]  visible_o
);

  import hex_pkg::*;

  localparam int CNT_W = (BLINK_HALF_PERIOD > 1) ? $clog2(BLINK_HALF_PERIOD) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLINK_HALF_PERIOD - 1);

  logic [CNT_W-1:0]      blink_cnt;
  logic                  half_done;
  logic                  blink_on;   // 0 is the off phase
  logic [NUM_DIGITS-1:0] visible_d;

  assign half_done = (blink_cnt == CNT_LAST);

  // blink timebase
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      blink_cnt <= '0;
    end else if (half_done) begin
      blink_cnt <= '0;
    end else begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      blink_on <= 1'b0; // starts dark
    end else if (half_done) begin
      blink_on <= ~blink_on;
    end
  end

  // only selections 0..3 point at a digit
  always_comb begin
    for (int n = 0; n < NUM_DIGITS; n++) begin
      visible_d[n] = digit_en_i[n] && !((blink_sel_i == 8'(n)) && !blink_on);
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      visible_o <= '0;
    end else begin
      visible_o <= visible_d;
    end
  end

  // digit values trail the value register by one cycle
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      digits_o <= '0;
    end else begin
      digits_o <= digits_i;
    end
  end

endmodule

//--- rtl/hex_regs.sv
`timescale 1ns/1ps

module hex_regs (
  input  logic           clk_i,
  input  logic           rst_i,

  input  logic [31:0]    wdata_i,
  input  logic [31:0]    addr_i,
  input  logic [3:0]     be_i,
  input  logic           we_i,

  output logic [15:0]    digits_o,
  output hex_pkg::an_t   digit_en_o,
  output logic [7:0]     blink_sel_o,
  output logic [31:0]    out_o
);

  import hex_pkg::*;

  hex_reg_e    reg_sel;
  logic [15:0] value_q;
  an_t         digit_en_q;
  logic [7:0]  blink_sel_q;
  logic        value_we;
  logic        ctrl_we;

  assign reg_sel  = hex_reg_e'(addr_i[3]);
  assign value_we = we_i && (reg_sel == REG_VALUE);
  assign ctrl_we  = we_i && (reg_sel == REG_CTRL);

  // value register, one nibble per byte enable
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      value_q <= '0;
    end else if (value_we) begin
      for (int n = 0; n < NUM_DIGITS; n++) begin
        if (be_i[n]) begin
          value_q[n*4 +: 4] <= wdata_i[n*4 +: 4];
        end
      end
    end
  end

  // control register
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      digit_en_q  <= '0;
      blink_sel_q <= '0;
    end else if (ctrl_we) begin
      if (be_i[0]) begin
        digit_en_q <= wdata_i[NUM_DIGITS-1:0];
      end
      if (be_i[1]) begin
        blink_sel_q <= wdata_i[15:8]; // full byte so NO_BLINK fits
      end
    end
  end

  // readback, no wait states
  always_comb begin
    case (reg_sel)
      REG_VALUE: out_o = {16'h0000, value_q};
      REG_CTRL:  out_o = {16'h0000, blink_sel_q, 4'h0, digit_en_q};
      default:   out_o = '0;
    endcase
  end

  assign digits_o    = value_q;
  assign digit_en_o  = digit_en_q;
  assign blink_sel_o = blink_sel_q;

endmodule

//--- rtl/hex_pkg.sv
package hex_pkg;

  // panel size, byte enable mapping assumes one enable per digit
  localparam int NUM_DIGITS = 4;

  // one hex digit of the value register
  typedef logic [3:0] hex_digit_t;

  // segment pattern, active low, bit 6 is g and bit 0 is a
  typedef logic [6:0] seg_t;

  // anode vector, active low, one bit per digit
  typedef logic [NUM_DIGITS-1:0] an_t;

  // register select, taken from address bit 3
  typedef enum logic {
    REG_VALUE = 1'b0,
    REG_CTRL  = 1'b1
  } hex_reg_e;

  // blink selection code meaning no digit blinks
  localparam logic [7:0] NO_BLINK = 8'hFF;

endpackage
